//--- common/rv_exec_macros.svh
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// datapath widths
`define XLEN            32
`define SHAMT_W         5

// RV32I major opcodes
`define OPC_R           7'b0110011
`define OPC_I_ARITH     7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_FENCE       7'b0001111
`define OPC_SYSTEM      7'b1110011

`endif

//--- common/rv_exec_pkg.sv
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    ////////////////////////////////////////
    // decode enums
    ////////////////////////////////////////

    // operation class from the major opcode
    typedef enum logic [3:0] {
        ALU_OP_NONE     = 4'd0,
        ALU_OP_R        = 4'd1,
        ALU_OP_I_ARITH  = 4'd2,
        ALU_OP_I_LOAD   = 4'd3,
        ALU_OP_I_JUMP   = 4'd4,   // jalr
        ALU_OP_I_FENCE  = 4'd5,
        ALU_OP_I_SYS    = 4'd6,
        ALU_OP_S        = 4'd7,
        ALU_OP_B        = 4'd8,
        ALU_OP_J        = 4'd9,
        ALU_OP_U_LUI    = 4'd10,
        ALU_OP_U_AUIPC  = 4'd11
    } alu_op_e;

    typedef enum logic [4:0] {
        ALU_EXEC_NONE   = 5'd0,
        ALU_EXEC_ADD    = 5'd1,
        ALU_EXEC_SUB    = 5'd2,
        ALU_EXEC_ADD4A  = 5'd3,   // link value
        ALU_EXEC_PASSB  = 5'd4,
        ALU_EXEC_AND    = 5'd5,
        ALU_EXEC_OR     = 5'd6,
        ALU_EXEC_XOR    = 5'd7,
        ALU_EXEC_SLL    = 5'd8,
        ALU_EXEC_SRL    = 5'd9,
        ALU_EXEC_SRA    = 5'd10,
        ALU_EXEC_SLT    = 5'd11,
        ALU_EXEC_SLTU   = 5'd12,
        ALU_EXEC_EQ     = 5'd13,
        ALU_EXEC_NEQ    = 5'd14,
        ALU_EXEC_SGTE   = 5'd15,
        ALU_EXEC_SGTEU  = 5'd16
    } alu_exec_e;

    ////////////////////////////////////////
    // instruction views
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    // request / response
    typedef struct packed {
        instr_t             instr;
        logic [`XLEN-1:0]   rs1;
        logic [`XLEN-1:0]   rs2;
        logic [`XLEN-1:0]   pc;
    } exec_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic               taken;
        logic               illegal;
    } exec_rsp_t;

    typedef struct packed {
        logic               a_is_pc;
        logic               b_is_imm;
        logic [`XLEN-1:0]   imm;
    } opnd_sel_t;

endpackage

//--- alu/alu_core.sv
`include "rv_exec_macros.svh"

module alu_core import rv_exec_pkg::*; (
    input  alu_exec_e           i_exec,
    input  logic [`XLEN-1:0]    i_a,
    input  logic [`XLEN-1:0]    i_b,
    output logic [`XLEN-1:0]    o_result,
    output logic                o_cmp
);

    logic lt_s;
    logic lt_u;
    logic eq;

    assign lt_s = $signed(i_a) < $signed(i_b);
    assign lt_u = i_a < i_b;
    assign eq   = (i_a == i_b);

    always_comb begin
        o_result = '0;
        o_cmp    = 1'b0;
        case (i_exec)
            ALU_EXEC_ADD:   o_result = i_a + i_b;
            ALU_EXEC_SUB:   o_result = i_a - i_b;
            ALU_EXEC_ADD4A: o_result = i_a + `XLEN'd4;   // pc + 4
            ALU_EXEC_PASSB: o_result = i_b;
            ALU_EXEC_AND:   o_result = i_a & i_b;
            ALU_EXEC_OR:    o_result = i_a | i_b;
            ALU_EXEC_XOR:   o_result = i_a ^ i_b;
            // zero shift amount only, longer shifts run in the serial shifter
            ALU_EXEC_SLL,
            ALU_EXEC_SRL,
            ALU_EXEC_SRA:   o_result = i_a;
            ALU_EXEC_SLT: begin
                o_cmp    = lt_s;
                o_result = {{(`XLEN-1){1'b0}}, lt_s};
            end
            ALU_EXEC_SLTU: begin
                o_cmp    = lt_u;
                o_result = {{(`XLEN-1){1'b0}}, lt_u};
            end
            // branch compares leave the result at 0
            ALU_EXEC_EQ:    o_cmp = eq;
            ALU_EXEC_NEQ:   o_cmp = !eq;
            ALU_EXEC_SGTE:  o_cmp = !lt_s;
            ALU_EXEC_SGTEU: o_cmp = !lt_u;
            default: begin
                o_result = '0;
                o_cmp    = 1'b0;
            end
        endcase
    end

endmodule

//--- alu/serial_shifter.sv
`include "rv_exec_macros.svh"

module serial_shifter import rv_exec_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_load,
    input  logic                i_en,
    input  logic [`XLEN-1:0]    i_value,
    input  alu_exec_e           i_exec,
    output logic [`XLEN-1:0]    o_value
);

    logic [`XLEN-1:0] value_q;
    logic [`XLEN-1:0] src;
    logic [`XLEN-1:0] shifted;

    assign src = i_load ? i_value : value_q;   // load with en shifts at once

    always_comb begin
        case (i_exec)
            ALU_EXEC_SLL: shifted = {src[`XLEN-2:0], 1'b0};
            ALU_EXEC_SRA: shifted = {src[`XLEN-1], src[`XLEN-1:1]};   // sign fill
            default:      shifted = {1'b0, src[`XLEN-1:1]};
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            value_q <= '0;
        end else if (i_load || i_en) begin
            value_q <= i_en ? shifted : src;
        end
    end

    assign o_value = value_q;

endmodule

//--- alu/shift_counter.sv
`include "rv_exec_macros.svh"

module shift_counter (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_load,
    input  logic                    i_en,
    input  logic [`SHAMT_W-1:0]     i_count,
    output logic                    o_empty
);

    logic [`SHAMT_W-1:0] count_q;
    logic [`SHAMT_W-1:0] src;

    // empty looks through a load so a zero amount ends right away
    assign src     = i_load ? i_count : count_q;
    assign o_empty = (src == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else if (i_load || i_en) begin
            count_q <= i_en ? src - 1'b1 : src;
        end
    end

endmodule

//--- hw/opcode_decoder.sv
`include "rv_exec_macros.svh"

module opcode_decoder import rv_exec_pkg::*; (
    input  instr_t      i_instr,
    output alu_op_e     o_alu_op,
    output opnd_sel_t   o_sel
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    ////////////////////////////////////////
    // immediates
    ////////////////////////////////////////

    assign imm_i = {{20{i_instr.i.imm12[11]}}, i_instr.i.imm12};
    assign imm_s = {{20{i_instr.r.funct7[6]}}, i_instr.r.funct7, i_instr.r.rd};
    assign imm_b = {{19{i_instr.r.funct7[6]}}, i_instr.r.funct7[6], i_instr.r.rd[0],
                    i_instr.r.funct7[5:0], i_instr.r.rd[4:1], 1'b0};
    assign imm_u = {i_instr.r.funct7, i_instr.r.rs2, i_instr.r.rs1, i_instr.r.funct3, 12'b0};
    assign imm_j = {{11{i_instr.r.funct7[6]}}, i_instr.r.funct7[6],
                    i_instr.r.rs1, i_instr.r.funct3, i_instr.r.rs2[0],
                    i_instr.r.funct7[5:0], i_instr.r.rs2[4:1], 1'b0};

    always_comb begin
        o_alu_op       = ALU_OP_NONE;
        o_sel.a_is_pc  = 1'b0;
        o_sel.b_is_imm = 1'b1;
        o_sel.imm      = imm_i;
        case (i_instr.r.opcode)
            `OPC_R: begin
                o_alu_op       = ALU_OP_R;
                o_sel.b_is_imm = 1'b0;   // rs2
            end
            `OPC_I_ARITH: o_alu_op = ALU_OP_I_ARITH;
            `OPC_LOAD:    o_alu_op = ALU_OP_I_LOAD;
            `OPC_FENCE:   o_alu_op = ALU_OP_I_FENCE;
            `OPC_SYSTEM:  o_alu_op = ALU_OP_I_SYS;
            `OPC_JALR: begin
                o_alu_op      = ALU_OP_I_JUMP;
                o_sel.a_is_pc = 1'b1;
            end
            `OPC_STORE: begin
                o_alu_op  = ALU_OP_S;
                o_sel.imm = imm_s;
            end
            `OPC_BRANCH: begin
                o_alu_op       = ALU_OP_B;
                o_sel.b_is_imm = 1'b0;   // compare rs1 with rs2
                o_sel.imm      = imm_b;
            end
            `OPC_JAL: begin
                o_alu_op      = ALU_OP_J;
                o_sel.a_is_pc = 1'b1;
                o_sel.imm     = imm_j;
            end
            `OPC_LUI: begin
                o_alu_op  = ALU_OP_U_LUI;
                o_sel.imm = imm_u;
            end
            `OPC_AUIPC: begin
                o_alu_op      = ALU_OP_U_AUIPC;
                o_sel.a_is_pc = 1'b1;
                o_sel.imm     = imm_u;
            end
            default: o_alu_op = ALU_OP_NONE;   // unknown opcode
        endcase
    end

endmodule

//--- hw/alu_control.sv
module alu_control import rv_exec_pkg::*; (
    input  alu_op_e     i_alu_op,
    input  logic [6:0]  i_funct7,
    input  logic [2:0]  i_funct3,
    output alu_exec_e   o_alu_exec
);

    always_comb begin
        o_alu_exec = ALU_EXEC_NONE;
        case (i_alu_op)
            // u/j formats
            ALU_OP_J:       o_alu_exec = ALU_EXEC_ADD4A;
            ALU_OP_U_LUI:   o_alu_exec = ALU_EXEC_PASSB;
            ALU_OP_U_AUIPC: o_alu_exec = ALU_EXEC_ADD;
            // i/s address style
            ALU_OP_S:       o_alu_exec = ALU_EXEC_ADD;
            ALU_OP_I_SYS:   o_alu_exec = ALU_EXEC_ADD;
            ALU_OP_I_LOAD:  o_alu_exec = ALU_EXEC_ADD;
            ALU_OP_I_FENCE: o_alu_exec = ALU_EXEC_ADD;
            ALU_OP_I_JUMP:  o_alu_exec = ALU_EXEC_ADD4A;
            ALU_OP_B: begin
                case (i_funct3)
                    3'b000:  o_alu_exec = ALU_EXEC_EQ;
                    3'b001:  o_alu_exec = ALU_EXEC_NEQ;
                    3'b100:  o_alu_exec = ALU_EXEC_SLT;
                    3'b101:  o_alu_exec = ALU_EXEC_SGTE;
                    3'b110:  o_alu_exec = ALU_EXEC_SLTU;
                    3'b111:  o_alu_exec = ALU_EXEC_SGTEU;
                    default: o_alu_exec = ALU_EXEC_NONE;
                endcase
            end
            ALU_OP_I_ARITH: begin
                // funct7 only matters for the shifts
                casez ({i_funct7, i_funct3})
                    10'b???????_000: o_alu_exec = ALU_EXEC_ADD;
                    10'b???????_010: o_alu_exec = ALU_EXEC_SLT;
                    10'b???????_011: o_alu_exec = ALU_EXEC_SLTU;
                    10'b???????_100: o_alu_exec = ALU_EXEC_XOR;
                    10'b???????_110: o_alu_exec = ALU_EXEC_OR;
                    10'b???????_111: o_alu_exec = ALU_EXEC_AND;
                    10'b0000000_001: o_alu_exec = ALU_EXEC_SLL;
                    10'b0000000_101: o_alu_exec = ALU_EXEC_SRL;
                    10'b0100000_101: o_alu_exec = ALU_EXEC_SRA;
                    default:         o_alu_exec = ALU_EXEC_NONE;
                endcase
            end
            ALU_OP_R: begin
                case ({i_funct7, i_funct3})
                    10'b0000000_000: o_alu_exec = ALU_EXEC_ADD;
                    10'b0100000_000: o_alu_exec = ALU_EXEC_SUB;
                    10'b0000000_001: o_alu_exec = ALU_EXEC_SLL;
                    10'b0000000_010: o_alu_exec = ALU_EXEC_SLT;
                    10'b0000000_011: o_alu_exec = ALU_EXEC_SLTU;
                    10'b0000000_100: o_alu_exec = ALU_EXEC_XOR;
                    10'b0000000_101: o_alu_exec = ALU_EXEC_SRL;
                    10'b0100000_101: o_alu_exec = ALU_EXEC_SRA;
                    10'b0000000_110: o_alu_exec = ALU_EXEC_OR;
                    10'b0000000_111: o_alu_exec = ALU_EXEC_AND;
                    default:         o_alu_exec = ALU_EXEC_NONE;
                endcase
            end
            default: o_alu_exec = ALU_EXEC_NONE;
        endcase
    end

endmodule

//--- hw/exec_fsm.sv
`include "rv_exec_macros.svh"

module exec_fsm import rv_exec_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  alu_exec_e           i_exec,
    input  logic                i_empty,
    input  logic [`XLEN-1:0]    i_alu_result,
    input  logic                i_cmp,
    input  logic [`XLEN-1:0]    i_shift_value,
    input  logic                i_is_branch,
    output logic                o_load,
    output logic                o_shift_en,
    output logic                o_busy,
    output logic                o_done,
    output exec_rsp_t           o_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_SHIFT,
        ST_DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   is_shift;
    logic   finish;
    logic   illegal;

    assign is_shift = (i_exec == ALU_EXEC_SLL) || (i_exec == ALU_EXEC_SRL) ||
                      (i_exec == ALU_EXEC_SRA);
    assign illegal  = (i_exec == ALU_EXEC_NONE);

    // load doubles as the first shift and a zero amount ends in EXEC
    assign o_load     = (state_q == ST_EXEC) && is_shift;
    assign o_shift_en = (o_load || (state_q == ST_SHIFT)) && !i_empty;
    assign finish     = ((state_q == ST_EXEC) && (!is_shift || i_empty)) ||
                        ((state_q == ST_SHIFT) && i_empty);

    assign o_busy = (state_q != ST_IDLE);
    assign o_done = (state_q == ST_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (i_start) state_d = ST_EXEC;
            ST_EXEC:  state_d = finish ? ST_DONE : ST_SHIFT;
            ST_SHIFT: if (finish) state_d = ST_DONE;
            default:  state_d = ST_IDLE;   // done lasts one cycle
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            o_rsp   <= '0;
        end else begin
            state_q <= state_d;
            if (finish) begin
                o_rsp.result  <= illegal ? '0 :
                                 (state_q == ST_SHIFT) ? i_shift_value : i_alu_result;
                o_rsp.taken   <= i_is_branch && i_cmp;
                o_rsp.illegal <= illegal;
            end
        end
    end

endmodule

//--- hw/rv_exec_top.sv
`include "rv_exec_macros.svh"

module rv_exec_top import rv_exec_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  exec_req_t   i_req,
    output exec_rsp_t   o_rsp,
    output logic        o_done,
    output logic        o_busy
);

    exec_req_t          req_q;
    alu_op_e            alu_op;
    alu_exec_e          alu_exec;
    opnd_sel_t          sel;
    logic [`XLEN-1:0]   opnd_a;
    logic [`XLEN-1:0]   opnd_b;
    logic [`XLEN-1:0]   alu_result;
    logic               alu_cmp;
    logic [`XLEN-1:0]   shift_value;
    logic               shift_load;
    logic               shift_en;
    logic               cnt_empty;

    ////////////////////////////////////////
    // request capture
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin   // start while busy is dropped
            req_q <= i_req;
        end
    end

    ////////////////////////////////////////
    // decode and operands
    ////////////////////////////////////////

    opcode_decoder i_opcode_decoder (
        .i_instr    (req_q.instr),
        .o_alu_op   (alu_op),
        .o_sel      (sel)
    );

    alu_control i_alu_control (
        .i_alu_op   (alu_op),
        .i_funct7   (req_q.instr.r.funct7),
        .i_funct3   (req_q.instr.r.funct3),
        .o_alu_exec (alu_exec)
    );

    assign opnd_a = sel.a_is_pc  ? req_q.pc : req_q.rs1;
    assign opnd_b = sel.b_is_imm ? sel.imm  : req_q.rs2;

    alu_core i_alu_core (
        .i_exec     (alu_exec),
        .i_a        (opnd_a),
        .i_b        (opnd_b),
        .o_result   (alu_result),
        .o_cmp      (alu_cmp)
    );

    serial_shifter i_serial_shifter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_load     (shift_load),
        .i_en       (shift_en),
        .i_value    (opnd_a),
        .i_exec     (alu_exec),
        .o_value    (shift_value)
    );

    shift_counter i_shift_counter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_load     (shift_load),
        .i_en       (shift_en),
        .i_count    (opnd_b[`SHAMT_W-1:0]),   // shamt
        .o_empty    (cnt_empty)
    );

    exec_fsm i_exec_fsm (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_exec         (alu_exec),
        .i_empty        (cnt_empty),
        .i_alu_result   (alu_result),
        .i_cmp          (alu_cmp),
        .i_shift_value  (shift_value),
        .i_is_branch    (alu_op == ALU_OP_B),
        .o_load         (shift_load),
        .o_shift_en     (shift_en),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_rsp          (o_rsp)
    );

endmodule

//--- bench/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// expected response and start-to-done latency of one request
function automatic exec_rsp_t ref_exec(input exec_req_t req, output int lat);
    logic [31:0] w;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic        lt_s;
    logic        lt_u;
    logic        ok;
    int          sh;
    exec_rsp_t   rsp;

    w     = req.instr;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_u = {w[31:12], 12'b0};
    rsp   = '0;
    lat   = 2;
    ok    = 1'b1;

    case (opc)
        `OPC_R, `OPC_I_ARITH: begin
            a    = req.rs1;
            b    = (opc == `OPC_R) ? req.rs2 : imm_i;
            sh   = b[4:0];
            lt_s = $signed(a) < $signed(b);
            lt_u = a < b;
            if (opc == `OPC_R) begin
                ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101));
            end else if (f3 == 3'b001) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'b101) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            case (f3)
                3'b000: rsp.result = (opc == `OPC_R && f7[5]) ? a - b : a + b;
                3'b001: begin
                    rsp.result = a << sh;
                    lat        = 2 + sh;
                end
                3'b010: rsp.result = {31'b0, lt_s};
                3'b011: rsp.result = {31'b0, lt_u};
                3'b100: rsp.result = a ^ b;
                3'b101: begin
                    if (f7[5]) begin
                        rsp.result = $signed(a) >>> sh;   // sign fill
                    end else begin
                        rsp.result = a >> sh;
                    end
                    lat = 2 + sh;
                end
                3'b110: rsp.result = a | b;
                default: rsp.result = a & b;
            endcase
        end
        `OPC_BRANCH: begin
            lt_s = $signed(req.rs1) < $signed(req.rs2);
            lt_u = req.rs1 < req.rs2;
            case (f3)
                3'b000: rsp.taken = (req.rs1 == req.rs2);
                3'b001: rsp.taken = (req.rs1 != req.rs2);
                3'b100: begin
                    rsp.taken  = lt_s;
                    rsp.result = {31'b0, lt_s};
                end
                3'b101: rsp.taken = !lt_s;
                3'b110: begin
                    rsp.taken  = lt_u;
                    rsp.result = {31'b0, lt_u};
                end
                3'b111: rsp.taken = !lt_u;
                default: ok = 1'b0;
            endcase
        end
        `OPC_LUI:   rsp.result = imm_u;
        `OPC_AUIPC: rsp.result = req.pc + imm_u;
        `OPC_JAL, `OPC_JALR: rsp.result = req.pc + 32'd4;   // link
        `OPC_STORE: rsp.result = req.rs1 + imm_s;
        `OPC_LOAD, `OPC_FENCE, `OPC_SYSTEM: rsp.result = req.rs1 + imm_i;
        default: ok = 1'b0;
    endcase

    if (!ok) begin
        rsp         = '0;
        rsp.illegal = 1'b1;
        lat         = 2;
    end
    return rsp;
endfunction

`endif

//--- bench/tb_rv_exec.sv
`include "rv_exec_macros.svh"

module tb_rv_exec import rv_exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ARITH     = 4;   // per op and form
    localparam int N_MISC      = 3;
    localparam int N_REQ       = 13 * N_ARITH + 3 * 2 * 32 + 6 * 5 + 8 * N_MISC + 8 + 1;
    localparam int CYC_PER_REQ = 40;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_start;
    exec_req_t  i_req;
    exec_rsp_t  o_rsp;
    logic       o_done;
    logic       o_busy;

    exec_rsp_t  exp_rsp_q[$];
    int         exp_lat_q[$];
    int         accept_q[$];
    int         n_sent;
    int         n_done;

    `include "exec_ref.svh"

    rv_exec_top i_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_req      (i_req),
        .o_rsp      (o_rsp),
        .o_done     (o_done),
        .o_busy     (o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_rsp(input string name, input exec_rsp_t got, input exec_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "FAILED %0t: %s (result/taken/illegal) got %h/%b/%b expected %h/%b/%b",
                $time, name, got.result, got.taken, got.illegal,
                exp.result, exp.taken, exp.illegal));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("FAILED %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'($urandom), f3, 5'($urandom), opc};
    endfunction

    function automatic exec_req_t rand_req(input logic [31:0] w);
        exec_req_t req;
        req.instr = w;
        req.rs1   = $urandom;
        req.rs2   = $urandom;
        req.pc    = $urandom & ~32'h3;
        return req;
    endfunction

    task automatic issue_req(input exec_req_t req);
        exec_rsp_t exp;
        int        lat;
        exp = ref_exec(req, lat);
        @(negedge i_clk);
        while (o_busy) @(negedge i_clk);
        exp_rsp_q.push_back(exp);
        exp_lat_q.push_back(lat);
        i_req   = req;
        i_start = 1'b1;
        n_sent++;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_done();
        while (n_done < n_sent) @(negedge i_clk);
    endtask

    task automatic run_req(input exec_req_t req);
        issue_req(req);
        wait_done();
    endtask

    ////////////////////////////////////////
    // compare process
    ////////////////////////////////////////

    initial begin : compare
        int cyc;
        cyc = 0;
        forever begin
            @(posedge i_clk);
            cyc++;
            if (i_rst_n && i_start && !o_busy) begin
                accept_q.push_back(cyc);
            end
            if (i_rst_n && o_done) begin
                if (exp_rsp_q.size() == 0 || accept_q.size() == 0) begin
                    abort_run("o_done pulsed with no request outstanding");
                end else begin
                    check_rsp("o_rsp", o_rsp, exp_rsp_q.pop_front());
                    check_latency("o_done latency", cyc - accept_q.pop_front(),
                                  exp_lat_q.pop_front());
                    n_done++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (16 + N_REQ * CYC_PER_REQ) @(posedge i_clk);
        abort_run("watchdog expired before all requests completed");
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        exec_req_t   req;
        logic [31:0] w;
        logic [31:0] x;
        logic [31:0] y;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [6:0]  opc;

        void'($urandom(23));
        $timeformat(-9, 1, " ns", 0);
        n_sent  = 0;
        n_done  = 0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_req   = '0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_level("o_busy", o_busy, 1'b0);
        check_level("o_done", o_done, 1'b0);
        check_rsp("o_rsp", o_rsp, '0);

        // add, sub, logic and compares in r and i forms
        for (int k = 0; k < 8; k++) begin
            if (k == 1 || k == 5) continue;   // shifts come later
            for (int n = 0; n < N_ARITH; n++) begin
                run_req(rand_req(r_word(7'h00, 3'(k), `OPC_R)));
                run_req(rand_req(i_word(12'($urandom), 3'(k), `OPC_I_ARITH)));
            end
        end
        for (int n = 0; n < N_ARITH; n++) begin
            run_req(rand_req(r_word(7'h20, 3'b000, `OPC_R)));
        end

        // sll, srl, sra over every amount
        for (int k = 0; k < 3; k++) begin
            for (int sh = 0; sh < 32; sh++) begin
                f7    = (k == 2) ? 7'h20 : 7'h00;
                f3    = (k == 0) ? 3'b001 : 3'b101;
                x     = $urandom;
                x[31] = sh[0];   // negative half the time
                req          = rand_req(r_word(f7, f3, `OPC_R));
                req.rs1      = x;
                req.rs2[4:0] = 5'(sh);
                run_req(req);
                req     = rand_req(i_word({f7, 5'(sh)}, f3, `OPC_I_ARITH));
                req.rs1 = x;
                run_req(req);
            end
        end

        // branches on equal, less and greater pairs
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) continue;
            for (int p = 0; p < 5; p++) begin
                x = $urandom;
                y = $urandom;
                case (p)
                    0: y = x;
                    1: begin
                        x[31] = 1'b1;   // signed less but unsigned greater
                        y[31] = 1'b0;
                    end
                    2: begin
                        x[31] = 1'b0;
                        y[31] = 1'b1;
                    end
                    3: begin
                        x[31:30] = 2'b00;
                        y[31:30] = 2'b01;
                    end
                    default: begin
                        x[31:30] = 2'b01;
                        y[31:30] = 2'b00;
                    end
                endcase
                req     = rand_req(r_word(7'($urandom), 3'(k), `OPC_BRANCH));
                req.rs1 = x;
                req.rs2 = y;
                run_req(req);
            end
        end

        // u, j, jalr, memory and system formats
        for (int k = 0; k < 8; k++) begin
            case (k)
                0: opc = `OPC_LUI;
                1: opc = `OPC_AUIPC;
                2: opc = `OPC_JAL;
                3: opc = `OPC_JALR;
                4: opc = `OPC_LOAD;
                5: opc = `OPC_STORE;
                6: opc = `OPC_FENCE;
                default: opc = `OPC_SYSTEM;
            endcase
            for (int n = 0; n < N_MISC; n++) begin
                w      = $urandom;
                w[6:0] = opc;
                if (opc == `OPC_JALR) begin
                    w[14:12] = 3'b000;
                end
                run_req(rand_req(w));
            end
        end

        // illegal encodings
        run_req(rand_req(r_word(7'($urandom), 3'($urandom), 7'b1111111)));
        run_req(rand_req(r_word(7'($urandom), 3'($urandom), 7'b0000000)));
        run_req(rand_req(r_word(7'($urandom), 3'($urandom), 7'b1010111)));
        run_req(rand_req(r_word(7'b0000001, 3'b000, `OPC_R)));
        run_req(rand_req(r_word(7'b0100000, 3'b110, `OPC_R)));
        run_req(rand_req(r_word(7'($urandom), 3'b010, `OPC_BRANCH)));
        run_req(rand_req(r_word(7'($urandom), 3'b011, `OPC_BRANCH)));
        run_req(rand_req(r_word(7'b0100000, 3'b001, `OPC_I_ARITH)));

        // second start during a long sra must be dropped
        req         = rand_req(i_word({7'h20, 5'd31}, 3'b101, `OPC_I_ARITH));
        req.rs1[31] = 1'b1;
        issue_req(req);
        repeat (5) @(negedge i_clk);
        check_level("o_busy", o_busy, 1'b1);
        i_req   = rand_req(r_word(7'h00, 3'b000, `OPC_R));
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        wait_done();
        repeat (10) @(negedge i_clk);   // room for a stray o_done
        check_level("o_busy", o_busy, 1'b0);

        if (n_done == n_sent && exp_rsp_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("run ended with responses still outstanding");
        end
    end

endmodule

//--- verilog.f
+incdir+common
+incdir+bench
common/rv_exec_pkg.sv
alu/alu_core.sv
alu/serial_shifter.sv
alu/shift_counter.sv
hw/opcode_decoder.sv
hw/alu_control.sv
hw/exec_fsm.sv
hw/rv_exec_top.sv
bench/tb_rv_exec.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - common
    files:
      - common/rv_exec_pkg.sv
      - alu/alu_core.sv
      - alu/serial_shifter.sv
      - alu/shift_counter.sv
      - hw/opcode_decoder.sv
      - hw/alu_control.sv
      - hw/exec_fsm.sv
      - hw/rv_exec_top.sv
  - target: test
    include_dirs:
      - common
      - bench
    files:
      - bench/tb_rv_exec.sv
